/* verilog/retry_pkg.sv */
`default_nettype none

package retry_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data widths

    // Operand and result width
    localparam int OPA_W = 16;
    localparam int RES_W = 16;

    // Opcode field width
    localparam int OP_W = 2;

    // Packed item is {opcode, operand a, operand b}
    localparam int ITEM_W = OP_W + 2 * OPA_W;

    ////////////////////////////////////////////////////////////////////////////
    // Transaction id layout

    // Top bit is parity over the index bits
    localparam int ID_W  = 4;
    localparam int IDX_W = ID_W - 1;
    localparam int SLOTS = 2 ** (ID_W - 1);

    // Lane register stages
    localparam int LANE_DEPTH = 2;

    // Result bit flipped in lane B on a fault strobe
    localparam int FAULT_BIT = 0;

    // Saturating fault counter width
    localparam int CNT_W = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Enumerations

    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_XOR  = 2'd2,
        OP_ROTL = 2'd3
    } op_e;

    typedef enum logic [1:0] {
        ST_RUN   = 2'd0,
        ST_RETRY = 2'd1
    } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/retry_start.sv */
`timescale 1ns/1ns
`default_nettype none

module retry_start (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // Upstream connection
    input  logic [retry_pkg::ITEM_W-1:0] data_i,
    input  logic                        valid_i,
    output logic                        ready_o,

    // Downstream connection
    output logic [retry_pkg::ITEM_W-1:0] data_o,
    output logic [retry_pkg::ID_W-1:0]   id_o,
    output logic                        valid_o,
    input  logic                        ready_i,

    // Retry connection
    input  logic [retry_pkg::ID_W-1:0]   retry_id_i,
    input  logic                        retry_valid_i,
    output logic                        retry_ready_o
);

    import retry_pkg::*;

    logic [ID_W-1:0]   failed_id_q;
    logic              failed_valid_q;
    logic              retry_take;
    logic              issue;
    logic [ID_W-1:0]   counter_q;
    logic [IDX_W-1:0]  idx_next;
    logic [ITEM_W-1:0] storage_q [SLOTS];

    ////////////////////////////////////////////////////////////////////////////
    // Failed id holding register

    assign retry_take    = retry_valid_i & retry_ready_o;
    assign retry_ready_o = ready_i | ~failed_valid_q;

    // A new retry wins over clearing the one being re-issued
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            failed_valid_q <= 1'b0;
        end else if (retry_take) begin
            failed_valid_q <= 1'b1;
        end else if (failed_valid_q && ready_i) begin
            failed_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (retry_take) begin
            failed_id_q <= retry_id_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Id counter with parity on top

    assign issue    = valid_o & ready_i;
    assign idx_next = counter_q[IDX_W-1:0] + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            counter_q <= '0;
        end else if (issue) begin
            counter_q <= {^idx_next, idx_next};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Item storage written at the id being issued

    always_ff @(posedge clk_i) begin
        if (issue) begin
            storage_q[counter_q[IDX_W-1:0]] <= data_o;
        end
    end

    // Stored copy goes out ahead of new input
    always_comb begin
        if (failed_valid_q) begin
            data_o = storage_q[failed_id_q[IDX_W-1:0]];
        end else begin
            data_o = data_i;
        end
    end

    assign id_o = counter_q;

    // Upstream held off while a retry is waiting
    assign ready_o = ready_i & ~failed_valid_q;
    assign valid_o = valid_i | failed_valid_q;

    // Issued ids always carry correct parity
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> (id_o[ID_W-1] == ^id_o[IDX_W-1:0]))
    else $error("retry_start: id parity broken on issue");

endmodule

`default_nettype wire

/* verilog/op_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module op_lane (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         en_i,
    input  logic [retry_pkg::ITEM_W-1:0] item_i,
    input  logic [retry_pkg::ID_W-1:0]   id_i,
    input  logic                         valid_i,
    input  logic                         fault_i,
    output logic [retry_pkg::RES_W-1:0]  result_o,
    output logic [retry_pkg::ID_W-1:0]   id_o,
    output logic                         valid_o
);

    import retry_pkg::*;

    op_e               op;
    logic [OPA_W-1:0]  opa;
    logic [OPA_W-1:0]  opb;
    logic [2*OPA_W-1:0] rot_tmp;
    logic [RES_W-1:0]  calc;

    logic [RES_W-1:0]  s1_result_q;
    logic [ID_W-1:0]   s1_id_q;
    logic              s1_valid_q;
    logic              s1_fault_q;

    // Unpack {op, a, b}
    assign op  = op_e'(item_i[ITEM_W-1 -: OP_W]);
    assign opa = item_i[2*OPA_W-1 -: OPA_W];
    assign opb = item_i[OPA_W-1:0];

    // Upper half of the doubled word gives the rotation
    assign rot_tmp = {opa, opa} << opb[3:0];

    always_comb begin
        case (op)
            OP_ADD:  calc = opa + opb;
            OP_SUB:  calc = opa - opb;
            OP_XOR:  calc = opa ^ opb;
            OP_ROTL: calc = rot_tmp[2*OPA_W-1 -: RES_W];
            default: calc = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s1_fault_q <= 1'b0;
        end else if (en_i) begin
            s1_valid_q <= valid_i;
            s1_fault_q <= fault_i & valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            s1_result_q <= calc;
            s1_id_q     <= id_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2 flips one bit on an injected fault

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            result_o <= s1_result_q ^ (RES_W'(s1_fault_q) << FAULT_BIT);
            id_o     <= s1_id_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/lane_compare.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_compare (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        en_i,
    input  logic [retry_pkg::RES_W-1:0] a_result_i,
    input  logic [retry_pkg::RES_W-1:0] b_result_i,
    input  logic [retry_pkg::ID_W-1:0]  a_id_i,
    input  logic [retry_pkg::ID_W-1:0]  b_id_i,
    input  logic                        a_valid_i,
    input  logic                        b_valid_i,
    output logic [retry_pkg::RES_W-1:0] result_o,
    output logic [retry_pkg::ID_W-1:0]  id_o,
    output logic                        valid_o,
    output logic                        match_o
);

    import retry_pkg::*;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= a_valid_i;
        end
    end

    // Lane A carries the result forward
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            result_o <= a_result_i;
            id_o     <= a_id_i;
            match_o  <= (a_result_i == b_result_i);
        end
    end

    // Both lanes are fed from one issue port and must stay in lockstep
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        a_valid_i == b_valid_i)
    else $error("lane_compare: lane valid bits differ");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        a_valid_i |-> (a_id_i == b_id_i))
    else $error("lane_compare: lane ids differ");

endmodule

`default_nettype wire

/* verilog/retry_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module retry_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [retry_pkg::RES_W-1:0] cmp_result_i,
    input  logic [retry_pkg::ID_W-1:0]  cmp_id_i,
    input  logic                        cmp_valid_i,
    input  logic                        cmp_match_i,
    input  logic                        out_ready_i,
    input  logic                        retry_ready_i,
    output logic [retry_pkg::RES_W-1:0] out_result_o,
    output logic                        out_valid_o,
    output logic [retry_pkg::ID_W-1:0]  retry_id_o,
    output logic                        retry_valid_o,
    output logic                        stall_n_o,
    output logic [retry_pkg::CNT_W-1:0] fault_count_o
);

    import retry_pkg::*;

    ctrl_state_e     state_q;
    ctrl_state_e     state_d;
    logic [ID_W-1:0] retry_id_q;
    logic            cmp_bad;
    logic            drop;

    assign cmp_bad = cmp_valid_i & ~cmp_match_i;

    // Only one retry in flight, so a second mismatch waits in the compare stage
    assign drop = cmp_bad & (state_q == ST_RUN);

    ////////////////////////////////////////////////////////////////////////////
    // Output and stall

    assign out_result_o = cmp_result_i;
    assign out_valid_o  = cmp_valid_i & cmp_match_i;

    // Advance when empty, dropping, or the consumer takes the result
    assign stall_n_o = ~cmp_valid_i | drop | (cmp_match_i & out_ready_i);

    ////////////////////////////////////////////////////////////////////////////
    // Retry FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (drop) begin
                    state_d = ST_RETRY;
                end
            end
            ST_RETRY: begin
                if (retry_ready_i) begin
                    state_d = ST_RUN;
                end
            end
            default: state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (drop) begin
            retry_id_q <= cmp_id_i;
        end
    end

    assign retry_valid_o = (state_q == ST_RETRY);
    assign retry_id_o    = retry_id_q;

    // Saturating mismatch count
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fault_count_o <= '0;
        end else if (drop && (fault_count_o != {CNT_W{1'b1}})) begin
            fault_count_o <= fault_count_o + 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmp_bad |-> !out_valid_o)
    else $error("retry_ctrl: mismatched result delivered");

endmodule

`default_nettype wire

/* verilog/retry_pipe_top.sv */
`timescale 1ns/1ns
`default_nettype none

module retry_pipe_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [retry_pkg::ITEM_W-1:0] in_item_i,
    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    output logic [retry_pkg::RES_W-1:0]  out_result_o,
    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    input  logic                         fault_i,
    output logic [retry_pkg::CNT_W-1:0]  fault_count_o
);

    import retry_pkg::*;

    // Issue port
    logic [ITEM_W-1:0] issue_item;
    logic [ID_W-1:0]   issue_id;
    logic              issue_valid;
    logic              stall_n;

    // Lane outputs
    logic [RES_W-1:0]  a_result;
    logic [ID_W-1:0]   a_id;
    logic              a_valid;
    logic [RES_W-1:0]  b_result;
    logic [ID_W-1:0]   b_id;
    logic              b_valid;

    // Compare stage
    logic [RES_W-1:0]  cmp_result;
    logic [ID_W-1:0]   cmp_id;
    logic              cmp_valid;
    logic              cmp_match;

    // Retry loop back
    logic [ID_W-1:0]   retry_id;
    logic              retry_valid;
    logic              retry_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Issue and duplicated lanes

    retry_start u_retry_start (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_i        (in_item_i),
        .valid_i       (in_valid_i),
        .ready_o       (in_ready_o),
        .data_o        (issue_item),
        .id_o          (issue_id),
        .valid_o       (issue_valid),
        .ready_i       (stall_n),
        .retry_id_i    (retry_id),
        .retry_valid_i (retry_valid),
        .retry_ready_o (retry_ready)
    );

    op_lane lane_a (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .en_i     (stall_n),
        .item_i   (issue_item),
        .id_i     (issue_id),
        .valid_i  (issue_valid),
        .fault_i  (1'b0),
        .result_o (a_result),
        .id_o     (a_id),
        .valid_o  (a_valid)
    );

    // Fault injection only on lane B
    op_lane lane_b (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .en_i     (stall_n),
        .item_i   (issue_item),
        .id_i     (issue_id),
        .valid_i  (issue_valid),
        .fault_i  (fault_i),
        .result_o (b_result),
        .id_o     (b_id),
        .valid_o  (b_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare and control

    lane_compare u_lane_compare (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .en_i       (stall_n),
        .a_result_i (a_result),
        .b_result_i (b_result),
        .a_id_i     (a_id),
        .b_id_i     (b_id),
        .a_valid_i  (a_valid),
        .b_valid_i  (b_valid),
        .result_o   (cmp_result),
        .id_o       (cmp_id),
        .valid_o    (cmp_valid),
        .match_o    (cmp_match)
    );

    retry_ctrl u_retry_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .cmp_result_i  (cmp_result),
        .cmp_id_i      (cmp_id),
        .cmp_valid_i   (cmp_valid),
        .cmp_match_i   (cmp_match),
        .out_ready_i   (out_ready_i),
        .retry_ready_i (retry_ready),
        .out_result_o  (out_result_o),
        .out_valid_o   (out_valid_o),
        .retry_id_o    (retry_id),
        .retry_valid_o (retry_valid),
        .stall_n_o     (stall_n),
        .fault_count_o (fault_count_o)
    );

endmodule

`default_nettype wire

/* bench/retry_pipe_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module retry_pipe_tb;

    import retry_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_INORDER  = 50;
    localparam int N_BP       = 60;
    localparam int N_FAULT    = 80;
    localparam int N_RESET    = 12;
    localparam int TOTAL_ITEMS = 2 * N_INORDER + N_BP + N_FAULT + N_RESET;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 20 + 200;

    logic              clk_i;
    logic              rst_n_i;
    logic [ITEM_W-1:0] in_item_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [RES_W-1:0]  out_result_o;
    logic              out_valid_o;
    logic              out_ready_i;
    logic              fault_i;
    logic [CNT_W-1:0]  fault_count_o;

    // Scoreboard of expected results with their acceptance times
    logic [RES_W-1:0]  sb_exp[$];
    time               sb_time[$];

    logic [31:0]       lfsr_state;
    logic              in_order;
    int                accepted_count;
    int                delivered_count;
    int                faults_applied;
    int                check_count;
    int                value_errors;
    int                other_errors;

    retry_pipe_top dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_item_i     (in_item_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .out_result_o  (out_result_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .fault_i       (fault_i),
        .fault_count_o (fault_count_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model

    // Galois form with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    function automatic logic [RES_W-1:0] expected_result(input logic [ITEM_W-1:0] item);
        op_e              op;
        logic [OPA_W-1:0] a;
        logic [OPA_W-1:0] b;
        int               sh;
        op = op_e'(item[ITEM_W-1 -: OP_W]);
        a  = item[2*OPA_W-1 -: OPA_W];
        b  = item[OPA_W-1:0];
        sh = b[3:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_ROTL: begin
                if (sh == 0) begin
                    return a;
                end
                return (a << sh) | (a >> (OPA_W - sh));
            end
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reporting

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            value_errors++;
            $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string text);
        other_errors++;
        $display("%0t: %s", $time, text);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Checks: %0d, value errors: %0d, other errors: %0d, timeout: %0d",
                 check_count, value_errors, other_errors, timed_out);
        if (timed_out || value_errors != 0 || other_errors != 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic apply_reset();
        rst_n_i     <= 1'b0;
        in_valid_i  <= 1'b0;
        fault_i     <= 1'b0;
        out_ready_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        sb_exp.delete();
        sb_time.delete();
        faults_applied  = 0;
        accepted_count  = 0;
        delivered_count = 0;
        check_value("out_valid_o", 0, out_valid_o);
        check_value("fault_count_o", 0, fault_count_o);
        rst_n_i <= 1'b1;
    endtask

    // Holds each item until accepted, strobing fault_i on its first cycle only
    task automatic run_items(input int n, input bit faults_on, input bit gaps_on,
                             input bit bp_on);
        int          sent;
        logic        pending;
        logic [31:0] op_bits;
        logic [31:0] a_bits;
        logic [31:0] b_bits;
        sent    = 0;
        pending = 1'b0;
        while (sent < n) begin
            @(posedge clk_i);
            if (in_valid_i && in_ready_o) begin
                sent++;
                pending = 1'b0;
            end
            fault_i <= 1'b0;
            if (bp_on) begin
                out_ready_i <= (rand_bits(2) != 0);
            end else begin
                out_ready_i <= 1'b1;
            end
            if (!pending && sent < n) begin
                if (gaps_on && rand_bits(2) == 0) begin
                    in_valid_i <= 1'b0;
                end else begin
                    op_bits = rand_bits(OP_W);
                    a_bits  = rand_bits(OPA_W);
                    b_bits  = rand_bits(OPA_W);
                    in_item_i  <= {op_bits[OP_W-1:0], a_bits[OPA_W-1:0], b_bits[OPA_W-1:0]};
                    in_valid_i <= 1'b1;
                    fault_i    <= faults_on && (rand_bits(3) == 0);
                    pending = 1'b1;
                end
            end else if (!pending) begin
                in_valid_i <= 1'b0;
            end
        end
    endtask

    // Idle tail also catches any stray out_valid_o
    task automatic drain();
        @(posedge clk_i);
        out_ready_i <= 1'b1;
        in_valid_i  <= 1'b0;
        fault_i     <= 1'b0;
        while (sb_exp.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (20) @(posedge clk_i);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor and scoreboard

    always @(posedge clk_i) begin : monitor
        logic             stalled_q;
        logic [RES_W-1:0] stalled_result;
        logic [CNT_W-1:0] last_fault_count;
        int               ready_wait;
        int               found;
        int               i;
        if (!rst_n_i) begin
            stalled_q        = 1'b0;
            last_fault_count = '0;
            ready_wait       = 0;
        end else begin
            if (in_valid_i && in_ready_o) begin
                sb_exp.push_back(expected_result(in_item_i));
                sb_time.push_back($time);
                accepted_count++;
            end
            // Strobe only counts when an item enters lane B
            if (fault_i && dut_i.issue_valid && dut_i.stall_n) begin
                faults_applied++;
            end
            if (stalled_q) begin
                check_value("out_valid_o", 1, out_valid_o);
                check_value("out_result_o", stalled_result, out_result_o);
            end
            stalled_q      = out_valid_o && !out_ready_i;
            stalled_result = out_result_o;
            if (out_valid_o && out_ready_i) begin
                delivered_count++;
                if (delivered_count > accepted_count) begin
                    report_problem("more results delivered than items accepted");
                end
                if (sb_exp.size() == 0) begin
                    report_problem($sformatf("result 0x%0h delivered with nothing outstanding",
                                             out_result_o));
                end else if (in_order) begin
                    check_value("out_result_o", sb_exp[0], out_result_o);
                    check_value("latency_cycles", 3, ($time - sb_time[0]) / CLK_PERIOD);
                    sb_exp.pop_front();
                    sb_time.pop_front();
                end else begin
                    found = -1;
                    for (i = 0; i < sb_exp.size(); i++) begin
                        if (found < 0 && sb_exp[i] == out_result_o) begin
                            found = i;
                        end
                    end
                    check_count++;
                    if (found < 0) begin
                        report_problem($sformatf("result 0x%0h matches no outstanding item",
                                                 out_result_o));
                    end else begin
                        sb_exp.delete(found);
                        sb_time.delete(found);
                    end
                end
            end
            // Upstream must be held off while a dropped item waits for re-issue
            if (fault_count_o != last_fault_count) begin
                last_fault_count = fault_count_o;
                ready_wait = 1;
            end
            if (ready_wait > 0) begin
                if (!in_ready_o) begin
                    ready_wait = 0;
                end else if (ready_wait >= 4) begin
                    report_problem("in_ready_o stayed high after a detected fault");
                    ready_wait = 0;
                end else begin
                    ready_wait++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_run(1'b1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        in_item_i   = '0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        fault_i     = 1'b0;
        lfsr_state  = 32'h598c_c892;
        in_order    = 1'b1;
        apply_reset();

        // Clean traffic with fixed latency and order
        run_items(N_INORDER, 1'b0, 1'b0, 1'b0);
        drain();

        // Random valid gaps and back-pressure
        in_order = 1'b0;
        run_items(N_BP, 1'b0, 1'b1, 1'b1);
        drain();

        // Injected faults on top of back-pressure
        run_items(N_FAULT, 1'b1, 1'b1, 1'b1);
        drain();
        check_value("fault_count_o", faults_applied, fault_count_o);
        if (faults_applied == 0) begin
            report_problem("no fault strobe reached an item");
        end

        // Reset with items still in the lanes, then clean traffic again
        run_items(N_RESET, 1'b1, 1'b0, 1'b0);
        apply_reset();
        in_order = 1'b1;
        run_items(N_INORDER, 1'b0, 1'b0, 1'b0);
        drain();
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

/* compile.f */
verilog/retry_pkg.sv
verilog/retry_start.sv
verilog/op_lane.sv
verilog/lane_compare.sv
verilog/retry_ctrl.sv
verilog/retry_pipe_top.sv
bench/retry_pipe_tb.sv
